// ==== compile.f ====
+incdir+hw
hw/sd_pkg.sv
hw/sd_cmd_if.sv
hw/sd_cmd_rx.sv
hw/sd_crc16.sv
hw/sd_block_ram.sv
hw/sd_card_ctrl.sv
hw/sd_card_spi.sv
bench/sd_clk_gen.sv
bench/sd_card_tb.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = sd_card_tb
FILELIST   = compile.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/sd_card_tb.sv ====
`timescale 1ns/1ns
`include "sd_defs.svh"

module sd_card_tb;
  import sd_pkg::*;

  // Bit slots of one block transfer including token, CRC and command overhead
  localparam int block_cycles = 8 * (`SD_BLOCK_BYTES + 24);
  localparam int max_cycles   = 12 * block_cycles + 10000;

  logic sck;
  logic rst;
  logic cs;
  logic mosi;
  logic miso;
  logic cmd_error;

  logic [31:0] rng_state;
  logic [7:0]  block_data [`SD_BLOCK_BYTES];
  string       test_name;
  int          error_count;
  int          check_count;
  int          errors_at_start;
  int          test_count;
  int          bad_tests;
  int          cycle_count;

  sd_clk_gen i_clk_gen (
    .sck (sck),
    .rst (rst)
  );

  sd_card_spi #(
    .sdsc (1'b0)
  ) i_dut (
    .sck       (sck),
    .rst       (rst),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .cmd_error (cmd_error)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // CRC7 over the first 40 bits of a command with polynomial x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ bits[i];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  // CRC16 CCITT shifted MSB first from a zero start value
  function automatic logic [15:0] crc16_byte(input logic [15:0] c, input logic [7:0] d);
    logic [15:0] r;
    logic        fb;
    r = c;
    for (int i = 7; i >= 0; i--) begin
      fb = r[15] ^ d[i];
      r  = {r[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
    return r;
  endfunction

  task automatic check_r1(input string what, input sd_r1_t exp, input sd_r1_t act);
    logic [7:0] e;
    logic [7:0] a;
    e = exp;
    a = act;
    check_count++;
    if (e !== a) begin
      error_count++;
      $display("Error: %s: %s expected %h, actual %h", test_name, what, e, a);
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_crc16(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Error: %s: %s expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    test_count++;
    if (error_count == errors_at_start) begin
      $display("%s: ok", test_name);
    end else begin
      bad_tests++;
      $display("%s: %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  // One byte in each direction
  // Mosi changes after the rising edge and miso is read at the falling edge
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge sck);
      mosi <= tx[i];
      @(negedge sck);
      rx[i] = miso;
    end
  endtask

  task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg, input bit bad_crc);
    logic [39:0] head;
    logic [6:0]  crc;
    logic [47:0] frame;
    logic [7:0]  ignored;
    head = {2'b01, index, arg};
    crc  = crc7_of(head);
    if (bad_crc) begin
      crc = crc ^ 7'h01;
    end
    frame = {head, crc, 1'b1};
    for (int i = 5; i >= 0; i--) begin
      xfer_byte(frame[i*8 +: 8], ignored);
    end
  endtask

  // Skips filler until a byte with bit 7 low
  task automatic get_resp(output logic [7:0] resp);
    int tries;
    tries = 0;
    xfer_byte(8'hFF, resp);
    while (resp[7] && tries < 8) begin
      tries++;
      xfer_byte(8'hFF, resp);
    end
    if (resp[7]) begin
      error_count++;
      $display("%s: the card sent no response within 9 bytes", test_name);
    end
  endtask

  task automatic run_cmd(input logic [5:0] index, input logic [31:0] arg, input bit bad_crc,
                         output sd_r1_t r1);
    logic [7:0] resp;
    send_cmd(index, arg, bad_crc);
    get_resp(resp);
    r1 = sd_r1_t'(resp);
  endtask

  task automatic find_token(output logic [7:0] token);
    int tries;
    tries = 0;
    xfer_byte(8'hFF, token);
    while (token == 8'hFF && tries < 8) begin
      tries++;
      xfer_byte(8'hFF, token);
    end
  endtask

  task automatic wait_busy(output int zeros, output logic [7:0] last);
    zeros = 0;
    xfer_byte(8'hFF, last);
    while (last == 8'h00 && zeros < 64) begin
      zeros++;
      xfer_byte(8'hFF, last);
    end
  endtask

  task automatic fill_block();
    for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
      rng_state     = xorshift32(rng_state);
      block_data[i] = rng_state[7:0];
    end
  endtask

  task automatic send_block(input int block, input bit flip, output logic [7:0] dresp);
    sd_r1_t      r1;
    logic [7:0]  ignored;
    logic [15:0] crc;
    run_cmd(cmd24, block, 1'b0, r1);
    check_r1("CMD24 R1", sd_r1_t'(8'h00), r1);
    xfer_byte(8'hFF, ignored);
    xfer_byte(8'hFE, ignored);
    crc = '0;
    for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
      xfer_byte(block_data[i], ignored);
      crc = crc16_byte(crc, block_data[i]);
    end
    if (flip) begin
      crc = crc ^ 16'h0020;
    end
    xfer_byte(crc[15:8], ignored);
    xfer_byte(crc[7:0], ignored);
    get_resp(dresp);
  endtask

  task automatic init_card();
    sd_r1_t     r1;
    logic [7:0] b;
    begin_test("init");
    check_flag("cmd_error after reset", 1'b0, cmd_error);
    // Card wakes up with cs high and a run of clocks
    repeat (10) begin
      xfer_byte(8'hFF, b);
      check_byte("miso while deselected", 8'hFF, b);
    end
    @(posedge sck);
    cs <= 1'b0;
    run_cmd(cmd0, 32'h0, 1'b0, r1);
    check_r1("CMD0", sd_r1_t'(8'h01), r1);
    run_cmd(cmd8, 32'h0000_01AA, 1'b0, r1);
    check_r1("CMD8 R7 byte 0", sd_r1_t'(8'h01), r1);
    xfer_byte(8'hFF, b);
    check_byte("CMD8 R7 byte 1", 8'h00, b);
    xfer_byte(8'hFF, b);
    check_byte("CMD8 R7 byte 2", 8'h00, b);
    xfer_byte(8'hFF, b);
    check_byte("CMD8 R7 byte 3", 8'h01, b);
    xfer_byte(8'hFF, b);
    check_byte("CMD8 R7 byte 4", 8'hAA, b);
    run_cmd(cmd59, 32'h1, 1'b0, r1);
    check_r1("CMD59", sd_r1_t'(8'h01), r1);
    run_cmd(cmd55, 32'h0, 1'b0, r1);
    check_r1("first CMD55", sd_r1_t'(8'h01), r1);
    run_cmd(cmd41, 32'h4000_0000, 1'b0, r1);
    check_r1("first ACMD41", sd_r1_t'(8'h01), r1);
    run_cmd(cmd55, 32'h0, 1'b0, r1);
    check_r1("second CMD55", sd_r1_t'(8'h01), r1);
    run_cmd(cmd41, 32'h4000_0000, 1'b0, r1);
    check_r1("second ACMD41", sd_r1_t'(8'h00), r1);
    run_cmd(cmd16, `SD_BLOCK_BYTES, 1'b0, r1);
    check_r1("CMD16", sd_r1_t'(8'h00), r1);
    run_cmd(cmd13, 32'h0, 1'b0, r1);
    check_r1("CMD13 R2 byte 0", sd_r1_t'(8'h00), r1);
    xfer_byte(8'hFF, b);
    check_byte("CMD13 R2 byte 1", 8'h00, b);
    finish_test();
  endtask

  task automatic write_read_block();
    sd_r1_t      r1;
    logic [7:0]  b;
    logic [7:0]  hi;
    logic [15:0] crc;
    int          zeros;
    begin_test("write_read");
    fill_block();
    send_block(3, 1'b0, b);
    check_byte("data response", 8'h05, b);
    wait_busy(zeros, b);
    check_byte("busy bytes", 8'(`SD_BUSY_CYCLES / 8), 8'(zeros));
    check_byte("miso after busy", 8'hFF, b);
    run_cmd(cmd17, 32'd3, 1'b0, r1);
    check_r1("CMD17 R1", sd_r1_t'(8'h00), r1);
    find_token(b);
    check_byte("data token", 8'hFE, b);
    crc = '0;
    for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
      xfer_byte(8'hFF, b);
      check_byte($sformatf("read byte %0d", i), block_data[i], b);
      crc = crc16_byte(crc, block_data[i]);
    end
    xfer_byte(8'hFF, hi);
    xfer_byte(8'hFF, b);
    check_crc16("read CRC16", crc, {hi, b});
    finish_test();
  endtask

  task automatic bad_data_crc();
    logic [7:0] b;
    begin_test("bad_crc");
    fill_block();
    send_block(5, 1'b1, b);
    check_byte("data response", 8'h0B, b);
    xfer_byte(8'hFF, b);
    check_byte("miso after rejected block", 8'hFF, b);
    finish_test();
  endtask

  task automatic param_errors();
    sd_r1_t     r1;
    logic [7:0] b;
    begin_test("param_err");
    run_cmd(cmd17, `SD_NUM_BLOCKS, 1'b0, r1);
    check_r1("CMD17 out of range", sd_r1_t'(8'h40), r1);
    repeat (4) begin
      xfer_byte(8'hFF, b);
      check_byte("filler after refused read", 8'hFF, b);
    end
    run_cmd(cmd16, 32'd1024, 1'b0, r1);
    check_r1("CMD16 with 1024", sd_r1_t'(8'h40), r1);
    check_flag("cmd_error after parameter errors", 1'b0, cmd_error);
    finish_test();
  endtask

  task automatic illegal_cmds();
    sd_r1_t     r1;
    logic [7:0] b;
    begin_test("cmd_error");
    check_flag("cmd_error before", 1'b0, cmd_error);
    run_cmd(cmd13, 32'h0, 1'b1, r1);
    check_r1("CMD13 with bad CRC7", sd_r1_t'(8'h08), r1);
    check_flag("cmd_error after bad CRC7", 1'b1, cmd_error);
    run_cmd(6'd2, 32'h0, 1'b0, r1);
    check_r1("CMD2", sd_r1_t'(8'h04), r1);
    check_flag("cmd_error after", 1'b1, cmd_error);
    run_cmd(cmd13, 32'h0, 1'b0, r1);
    check_r1("CMD13 R2 byte 0", sd_r1_t'(8'h00), r1);
    xfer_byte(8'hFF, b);
    check_byte("CMD13 R2 byte 1", 8'h00, b);
    finish_test();
  endtask

  task automatic cs_abort();
    sd_r1_t     r1;
    logic [7:0] b;
    begin_test("cs_abort");
    run_cmd(cmd17, 32'd3, 1'b0, r1);
    check_r1("CMD17 R1", sd_r1_t'(8'h00), r1);
    find_token(b);
    check_byte("data token", 8'hFE, b);
    repeat (64) begin
      xfer_byte(8'hFF, b);
    end
    // Deselect in the middle of the block
    @(posedge sck);
    cs <= 1'b1;
    repeat (2) begin
      xfer_byte(8'hFF, b);
      check_byte("miso while deselected", 8'hFF, b);
    end
    @(posedge sck);
    cs <= 1'b0;
    run_cmd(cmd13, 32'h0, 1'b0, r1);
    check_r1("CMD13 R2 byte 0", sd_r1_t'(8'h00), r1);
    xfer_byte(8'hFF, b);
    check_byte("CMD13 R2 byte 1", 8'h00, b);
    finish_test();
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge sck);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    cs              = 1'b1;
    mosi            = 1'b1;
    rng_state       = 32'd33;
    error_count     = 0;
    check_count     = 0;
    errors_at_start = 0;
    test_count      = 0;
    bad_tests       = 0;
    @(negedge rst);
    @(posedge sck);
    init_card();
    write_read_block();
    bad_data_crc();
    param_errors();
    illegal_cmds();
    cs_abort();
    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             test_count, bad_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== bench/sd_clk_gen.sv ====
`timescale 1ns/1ns

module sd_clk_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 16
) (
  output logic sck,
  output logic rst
);

  initial begin
    sck = 1'b0;
    forever begin
      #half_period sck = ~sck;
    end
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge sck);
    rst <= 1'b0;
  end

endmodule

// ==== hw/sd_card_spi.sv ====
`timescale 1ns/1ns
`include "sd_defs.svh"

module sd_card_spi #(
  parameter bit sdsc = 1'b0
) (
  input  logic sck,
  input  logic rst,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output logic cmd_error
);

  logic [`SD_ADDR_BITS-1:0] ram_addr;
  logic                     ram_wr_en;
  logic [7:0]               ram_wr_data;
  logic [7:0]               ram_rd_data;
  logic                     crc_clear;
  logic                     crc_shift;
  logic                     crc_bit;
  logic [15:0]              crc;

  sd_cmd_if cmd_bus ();

  sd_cmd_rx i_cmd_rx (
    .sck  (sck),
    .rst  (rst),
    .cs   (cs),
    .mosi (mosi),
    .cmd  (cmd_bus.rx)
  );

  sd_card_ctrl #(
    .sdsc (sdsc)
  ) i_ctrl (
    .sck         (sck),
    .rst         (rst),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .cmd_error   (cmd_error),
    .cmd         (cmd_bus.ctrl),
    .ram_addr    (ram_addr),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_data (ram_wr_data),
    .ram_rd_data (ram_rd_data),
    .crc_clear   (crc_clear),
    .crc_shift   (crc_shift),
    .crc_bit     (crc_bit),
    .crc         (crc)
  );

  sd_block_ram i_ram (
    .sck     (sck),
    .addr    (ram_addr),
    .wr_en   (ram_wr_en),
    .wr_data (ram_wr_data),
    .rd_data (ram_rd_data)
  );

  sd_crc16 i_crc16 (
    .sck    (sck),
    .rst    (rst),
    .clear  (crc_clear),
    .shift  (crc_shift),
    .bit_in (crc_bit),
    .crc    (crc)
  );

endmodule

// ==== hw/sd_card_ctrl.sv ====
`timescale 1ns/1ns
`include "sd_defs.svh"

module sd_card_ctrl #(
  parameter bit sdsc = 1'b0
) (
  input  logic                     sck,
  input  logic                     rst,
  input  logic                     cs,
  input  logic                     mosi,
  output logic                     miso,
  output logic                     cmd_error,
  sd_cmd_if.ctrl                   cmd,
  output logic [`SD_ADDR_BITS-1:0] ram_addr,
  output logic                     ram_wr_en,
  output logic [7:0]               ram_wr_data,
  input  logic [7:0]               ram_rd_data,
  output logic                     crc_clear,
  output logic                     crc_shift,
  output logic                     crc_bit,
  input  logic [15:0]              crc
);
  import sd_pkg::*;

  localparam int byte_bits = $clog2(`SD_BLOCK_BYTES);

  sd_state_e                state;
  logic [12:0]              cnt;
  logic [39:0]              resp_sh;
  logic [7:0]               data_sh;
  logic [`SD_ADDR_BITS-1:0] byte_addr;
  logic                     rd_go;
  logic                     wr_go;
  logic                     idle;
  logic                     acmd41_seen;
  logic                     app_cmd;
  logic                     out_bit;

  sd_r1_t      r1;
  logic [31:0] resp_tail;
  logic [12:0] resp_len;
  logic        cmd_rd;
  logic        cmd_wr;
  logic        cmd_bad;
  logic        addr_ok;
  logic [31:0] blk_num;
  logic [31:0] blk_start;
  logic [7:0]  rx_byte;
  logic [15:0] rx_crc;
  logic        crc_match;

  // Standard capacity cards address bytes, others address blocks
  assign blk_num   = sdsc ? (cmd.argument >> byte_bits) : cmd.argument;
  assign blk_start = blk_num * `SD_BLOCK_BYTES;
  assign addr_ok   = (blk_num < `SD_NUM_BLOCKS) &&
                     (!sdsc || cmd.argument[byte_bits-1:0] == '0);

  assign rx_byte   = {data_sh[6:0], mosi};
  assign rx_crc    = {resp_sh[14:0], mosi};
  assign crc_match = (rx_crc == crc);

  always_comb begin
    r1        = '0;
    r1.idle   = idle;
    resp_tail = '1;
    resp_len  = 13'd8;
    cmd_rd    = 1'b0;
    cmd_wr    = 1'b0;
    if (!cmd.crc_ok || !cmd.frame_ok) begin
      r1.crc_err = 1'b1;
    end else begin
      case (cmd.index)
        cmd0, cmd55, cmd59: ;
        cmd8: begin
          // R7 echoes voltage and check pattern
          resp_len  = 13'd40;
          resp_tail = {20'h00000, cmd.argument[11:0]};
        end
        cmd13: begin
          resp_len  = 13'd16;
          resp_tail = {8'h00, 24'hFFFFFF};
        end
        cmd16: r1.param_err = (cmd.argument != `SD_BLOCK_BYTES);
        cmd17: begin
          r1.param_err = !addr_ok;
          cmd_rd       = addr_ok;
        end
        cmd24: begin
          r1.param_err = !addr_ok;
          cmd_wr       = addr_ok;
        end
        cmd41: begin
          r1.illegal_cmd = !app_cmd;
          // Second ACMD41 ends initialization
          if (app_cmd && acmd41_seen) begin
            r1.idle = 1'b0;
          end
        end
        default: r1.illegal_cmd = 1'b1;
      endcase
    end
  end

  assign cmd_bad = r1.crc_err || r1.illegal_cmd;

  always_ff @(posedge sck) begin
    if (rst) begin
      idle        <= 1'b1;
      acmd41_seen <= 1'b0;
      app_cmd     <= 1'b0;
      cmd_error   <= 1'b0;
    end else if (cmd.valid) begin
      idle    <= r1.idle;
      app_cmd <= !cmd_bad && cmd.index == cmd55;
      if (!cmd_bad && cmd.index == cmd41) begin
        acmd41_seen <= 1'b1;
      end
      if (cmd_bad) begin
        cmd_error <= 1'b1;
      end
    end
  end

  always_ff @(posedge sck) begin
    if (rst || cs) begin
      state      <= wait_cmd;
      cmd.listen <= 1'b1;
      cnt        <= '0;
      rd_go      <= 1'b0;
      wr_go      <= 1'b0;
    end else begin
      case (state)
        wait_cmd: begin
          if (cmd.valid) begin
            // Valid cycle is the first gap cycle
            state      <= ncr_gap;
            cmd.listen <= 1'b0;
            cnt        <= 13'(8 * `SD_NCR_BYTES - 2);
            resp_sh    <= {r1, resp_tail};
            rd_go      <= cmd_rd;
            wr_go      <= cmd_wr;
            byte_addr  <= blk_start[`SD_ADDR_BITS-1:0];
          end
        end
        ncr_gap: begin
          cnt <= cnt - 13'd1;
          if (cnt == '0) begin
            state <= send_resp;
            cnt   <= resp_len - 13'd1;
          end
        end
        send_resp: begin
          resp_sh <= {resp_sh[38:0], 1'b1};
          cnt     <= cnt - 13'd1;
          if (cnt == '0) begin
            if (rd_go) begin
              state <= nac_gap;
              cnt   <= 13'(8 * `SD_NAC_BYTES - 1);
            end else if (wr_go) begin
              state <= wait_token;
              cnt   <= 13'd7;
            end else begin
              state      <= wait_cmd;
              cmd.listen <= 1'b1;
            end
          end
        end
        nac_gap: begin
          cnt <= cnt - 13'd1;
          if (cnt == '0) begin
            state <= send_token;
            cnt   <= 13'd7;
          end
        end
        send_token: begin
          cnt <= cnt - 13'd1;
          if (cnt == '0) begin
            state     <= send_data;
            cnt       <= 13'(8 * `SD_BLOCK_BYTES - 1);
            data_sh   <= ram_rd_data;
            byte_addr <= byte_addr + 1'b1;
          end
        end
        send_data: begin
          cnt <= cnt - 13'd1;
          if (cnt == '0) begin
            state <= send_crc;
            cnt   <= 13'd15;
          end else if (cnt[2:0] == 3'd0) begin
            // Next byte was fetched during this one
            data_sh   <= ram_rd_data;
            byte_addr <= byte_addr + 1'b1;
          end else begin
            data_sh <= {data_sh[6:0], 1'b1};
          end
        end
        send_crc: begin
          cnt <= cnt - 13'd1;
          if (cnt == '0) begin
            state      <= wait_cmd;
            cmd.listen <= 1'b1;
          end
        end
        wait_token: begin
          data_sh <= rx_byte;
          cnt     <= (cnt == '0) ? 13'd7 : cnt - 13'd1;
          if (cnt == '0 && rx_byte == 8'hFE) begin
            state <= recv_data;
            cnt   <= 13'(8 * `SD_BLOCK_BYTES - 1);
          end
        end
        recv_data: begin
          data_sh <= rx_byte;
          cnt     <= cnt - 13'd1;
          if (cnt[2:0] == 3'd0) begin
            byte_addr <= byte_addr + 1'b1;
          end
          if (cnt == '0) begin
            state <= recv_crc;
            cnt   <= 13'd15;
          end
        end
        recv_crc: begin
          resp_sh <= {resp_sh[38:0], mosi};
          cnt     <= cnt - 13'd1;
          if (cnt == '0) begin
            state   <= send_dresp;
            cnt     <= 13'd7;
            wr_go   <= crc_match;
            resp_sh <= {(crc_match ? 8'h05 : 8'h0B), 32'hFFFFFFFF};
          end
        end
        send_dresp: begin
          resp_sh <= {resp_sh[38:0], 1'b1};
          cnt     <= cnt - 13'd1;
          if (cnt == '0) begin
            if (wr_go) begin
              state <= busy;
              cnt   <= 13'(`SD_BUSY_CYCLES - 1);
            end else begin
              state      <= wait_cmd;
              cmd.listen <= 1'b1;
            end
          end
        end
        busy: begin
          cnt <= cnt - 13'd1;
          if (cnt == '0) begin
            state      <= wait_cmd;
            cmd.listen <= 1'b1;
          end
        end
        default: begin
          state      <= wait_cmd;
          cmd.listen <= 1'b1;
        end
      endcase
    end
  end

  // Bytes are written as their last bit arrives
  assign ram_addr    = byte_addr;
  assign ram_wr_en   = (state == recv_data) && (cnt[2:0] == 3'd0);
  assign ram_wr_data = rx_byte;

  assign crc_clear = (state == send_token) || (state == wait_token);
  assign crc_shift = (state == send_data) || (state == recv_data);
  assign crc_bit   = (state == send_data) ? data_sh[7] : mosi;

  always_comb begin
    case (state)
      send_resp, send_dresp: out_bit = resp_sh[39];
      send_token:            out_bit = (cnt != '0);
      send_data:             out_bit = data_sh[7];
      send_crc:              out_bit = crc[cnt[3:0]];
      busy:                  out_bit = 1'b0;
      default:               out_bit = 1'b1;
    endcase
  end

  assign miso = cs | out_bit;

endmodule

// ==== hw/sd_block_ram.sv ====
`timescale 1ns/1ns
`include "sd_defs.svh"

module sd_block_ram (
  input  logic                     sck,
  input  logic [`SD_ADDR_BITS-1:0] addr,
  input  logic                     wr_en,
  input  logic [7:0]               wr_data,
  output logic [7:0]               rd_data
);

  localparam int depth = `SD_NUM_BLOCKS * `SD_BLOCK_BYTES;

  // Blank card
  logic [7:0] mem [depth] = '{default: 8'h00};

  always_ff @(posedge sck) begin
    if (wr_en) begin
      mem[addr] <= wr_data;
    end
    rd_data <= mem[addr];
  end

endmodule

// ==== hw/sd_crc16.sv ====
`timescale 1ns/1ns

module sd_crc16 (
  input  logic        sck,
  input  logic        rst,
  input  logic        clear,
  input  logic        shift,
  input  logic        bit_in,
  output logic [15:0] crc
);

  logic fb;

  // Polynomial x^16 + x^12 + x^5 + 1 shifted MSB first
  assign fb = crc[15] ^ bit_in;

  always_ff @(posedge sck) begin
    if (rst || clear) begin
      crc <= '0;
    end else if (shift) begin
      crc <= {crc[14:12], crc[11] ^ fb, crc[10:5], crc[4] ^ fb, crc[3:0], fb};
    end
  end

endmodule

// ==== hw/sd_cmd_rx.sv ====
`timescale 1ns/1ns

module sd_cmd_rx (
  input logic  sck,
  input logic  rst,
  input logic  cs,
  input logic  mosi,
  sd_cmd_if.rx cmd
);
  import sd_pkg::*;

  logic        active;
  logic [5:0]  bit_cnt;
  logic [46:0] frame;
  logic [47:0] full;
  logic [6:0]  crc7;
  logic [6:0]  crc7_next;
  logic        crc_fb;

  // Frame including the bit sampled at this edge
  assign full = {frame, mosi};

  // CRC7 with polynomial x^7 + x^3 + 1
  assign crc_fb    = crc7[6] ^ mosi;
  assign crc7_next = {crc7[5:3], crc7[2] ^ crc_fb, crc7[1:0], crc_fb};

  always_ff @(posedge sck) begin
    if (rst || cs) begin
      active    <= 1'b0;
      bit_cnt   <= '0;
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= 1'b0;
      if (!active) begin
        // Start bit opens a frame
        if (cmd.listen && !cmd.valid && !mosi) begin
          active  <= 1'b1;
          bit_cnt <= 6'd1;
        end
      end else if (bit_cnt == 6'd47) begin
        active    <= 1'b0;
        cmd.valid <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 6'd1;
      end
    end
  end

  always_ff @(posedge sck) begin
    frame <= full[46:0];
    if (!active) begin
      // A zero start bit leaves the CRC at zero
      crc7 <= '0;
    end else if (bit_cnt < 6'd40) begin
      crc7 <= crc7_next;
    end
    if (active && !cs && bit_cnt == 6'd47) begin
      cmd.index    <= sd_cmd_e'(full[45:40]);
      cmd.argument <= full[39:8];
      cmd.crc_ok   <= (full[7:1] == crc7);
      cmd.frame_ok <= full[46] && full[0];
    end
  end

endmodule

// ==== hw/sd_cmd_if.sv ====
`timescale 1ns/1ns

interface sd_cmd_if;
  import sd_pkg::*;

  logic        listen;
  logic        valid;
  sd_cmd_e     index;
  logic [31:0] argument;
  logic        crc_ok;
  logic        frame_ok;

  modport rx (
    input  listen,
    output valid, index, argument, crc_ok, frame_ok
  );

  modport ctrl (
    output listen,
    input  valid, index, argument, crc_ok, frame_ok
  );

endinterface

// ==== hw/sd_pkg.sv ====
package sd_pkg;

  typedef enum logic [5:0] {
    cmd0  = 6'd0,
    cmd8  = 6'd8,
    cmd13 = 6'd13,
    cmd16 = 6'd16,
    cmd17 = 6'd17,
    cmd24 = 6'd24,
    cmd41 = 6'd41,
    cmd55 = 6'd55,
    cmd59 = 6'd59
  } sd_cmd_e;

  typedef enum logic [3:0] {
    wait_cmd,
    ncr_gap,
    send_resp,
    nac_gap,
    send_token,
    send_data,
    send_crc,
    wait_token,
    recv_data,
    recv_crc,
    send_dresp,
    busy
  } sd_state_e;

  // R1 byte with bit 7 always zero
  typedef struct packed {
    logic zero;
    logic param_err;
    logic addr_err;
    logic erase_seq_err;
    logic crc_err;
    logic illegal_cmd;
    logic erase_reset;
    logic idle;
  } sd_r1_t;

endpackage

// ==== hw/sd_defs.svh ====
`ifndef SD_DEFS_SVH
`define SD_DEFS_SVH

// Card geometry
`define SD_BLOCK_BYTES 512
`define SD_NUM_BLOCKS 8

// Byte address into the whole block store
`define SD_ADDR_BITS $clog2(`SD_NUM_BLOCKS * `SD_BLOCK_BYTES)

// Cycles of miso low after an accepted write
`define SD_BUSY_CYCLES 16

// Filler bytes before a response and before a read token
`define SD_NCR_BYTES 1
`define SD_NAC_BYTES 1

`endif
